// File: bench/tb_ctrl_top.sv
// Control unit testbench
`timescale 1ns/1ps

module tb_ctrl_top;
   import or1k_spr_pkg::*;
   import or1k_exc_pkg::*;

   localparam int WAIT_LIMIT = 200;

   logic        clk;
   logic        rst;
   logic        insn_valid_i;
   insn_op_t    insn_op_i;
   word_t       pc_i;
   spr_addr_t   spr_addr_i;
   word_t       spr_wdat_i;
   word_t       eaddr_i;
   exc_req_t    except_i;
   logic [31:0] irq_i;
   logic        branch_taken_i;
   word_t       mfspr_dat_o;
   logic        mfspr_we_o;
   logic        branch_o;
   word_t       branch_pc_o;
   logic        flush_o;
   logic        stall_o;
   sr_t         sr_o;

   logic [31:0] lfsr;
   word_t       pc_cnt;
   word_t       evba_exp;

   ctrl_top DUT (
      .clk            (clk),
      .rst            (rst),
      .insn_valid_i   (insn_valid_i),
      .insn_op_i      (insn_op_i),
      .pc_i           (pc_i),
      .spr_addr_i     (spr_addr_i),
      .spr_wdat_i     (spr_wdat_i),
      .eaddr_i        (eaddr_i),
      .except_i       (except_i),
      .irq_i          (irq_i),
      .branch_taken_i (branch_taken_i),
      .mfspr_dat_o    (mfspr_dat_o),
      .mfspr_we_o     (mfspr_we_o),
      .branch_o       (branch_o),
      .branch_pc_o    (branch_pc_o),
      .flush_o        (flush_o),
      .stall_o        (stall_o),
      .sr_o           (sr_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic word_t rand_bits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Expected handler address, EPCR and EEAR for an exception entry
   function automatic void exp_entry(input exc_req_t req, input logic irq, input word_t pc,
                                     input word_t eaddr, input word_t evba,
                                     output word_t redir, output word_t epcr,
                                     output word_t eear);
      logic [4:0] vec;
      logic       after;
      logic       use_ea;
      after  = 1'b0;
      use_ea = 1'b0;
      if (req[EXC_BUS]) begin
         vec    = VEC_BUS;
         use_ea = 1'b1;
      end else if (req[EXC_ILLEGAL]) begin
         vec = VEC_ILLEGAL;
      end else if (req[EXC_ALIGN]) begin
         vec    = VEC_ALIGN;
         use_ea = 1'b1;
      end else if (req[EXC_SYSCALL]) begin
         vec   = VEC_SYSCALL;
         after = 1'b1;
      end else if (req[EXC_TRAP]) begin
         vec = VEC_TRAP;
      end else if (irq) begin
         vec   = VEC_INT;
         after = 1'b1;
      end else begin
         vec   = VEC_TICK;
         after = 1'b1;
      end
      redir = evba | (32'(vec) << 8);
      epcr  = after ? pc + 32'd4 : pc;
      eear  = use_ea ? eaddr : pc;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_sr(input string name, input sr_t got, input sr_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (stall_o) begin
         @(negedge clk);
         n++;
         if (n > WAIT_LIMIT)
            stop_run("Timed out waiting for stall_o to drop");
      end
   endtask

   // Drives one commit at a falling edge and returns at the next one
   task automatic issue(input insn_op_t op, input word_t pc, input spr_addr_t addr,
                        input word_t wdat, input exc_req_t exc);
      wait_idle();
      insn_valid_i = 1'b1;
      insn_op_i    = op;
      pc_i         = pc;
      spr_addr_i   = addr;
      spr_wdat_i   = wdat;
      except_i     = exc;
      @(negedge clk);
      insn_valid_i = 1'b0;
      insn_op_i    = OP_OTHER;
      except_i     = '0;
   endtask

   task automatic write_spr(input spr_addr_t addr, input word_t wdat);
      pc_cnt = pc_cnt + 32'd4;
      issue(OP_MTSPR, pc_cnt, addr, wdat, '0);
   endtask

   task automatic expect_spr(input string name, input spr_addr_t addr, input word_t exp);
      pc_cnt = pc_cnt + 32'd4;
      issue(OP_MFSPR, pc_cnt, addr, '0, '0);
      check_bit("mfspr_we_o", mfspr_we_o, 1'b1);
      check_word(name, mfspr_dat_o, exp);
      @(negedge clk);
      check_bit("mfspr_we_o", mfspr_we_o, 1'b0);
   endtask

   task automatic take_redirect(input word_t exp_pc);
      int n;
      n = 0;
      while (!branch_o) begin
         @(negedge clk);
         n++;
         if (n > WAIT_LIMIT)
            stop_run("Timed out waiting for branch_o");
      end
      check_word("branch_pc_o", branch_pc_o, exp_pc);
      check_bit("flush_o", flush_o, 1'b1);
      check_bit("stall_o", stall_o, 1'b1);
      // Fetch holds off for a few cycles
      repeat (rand_bits(2)) begin
         @(negedge clk);
         check_bit("branch_o", branch_o, 1'b1);
         check_bit("flush_o", flush_o, 1'b0);
      end
      branch_taken_i = 1'b1;
      @(negedge clk);
      branch_taken_i = 1'b0;
      check_bit("branch_o", branch_o, 1'b0);
      check_bit("stall_o", stall_o, 1'b1);
      wait_idle();
   endtask

   // Plain commits until an interrupt is taken
   task automatic commit_until_branch(output word_t last_pc);
      int n;
      n = 0;
      last_pc = pc_cnt;
      while (!branch_o) begin
         pc_cnt       = pc_cnt + 32'd4;
         insn_valid_i = 1'b1;
         insn_op_i    = OP_OTHER;
         pc_i         = pc_cnt;
         @(negedge clk);
         last_pc = pc_cnt;
         n++;
         if (n > WAIT_LIMIT)
            stop_run("Timed out waiting for an interrupt entry");
      end
      insn_valid_i = 1'b0;
   endtask

   initial begin
      word_t    v;
      word_t    pc;
      word_t    ea;
      word_t    redir;
      word_t    epcr;
      word_t    eear;
      sr_t      sr_val;
      sr_t      sr_exp;
      exc_req_t exc;
      int       k;
      lfsr           = 32'h8667e351;
      pc_cnt         = 32'h0000_1000;
      evba_exp       = '0;
      rst            = 1'b1;
      insn_valid_i   = 1'b0;
      insn_op_i      = OP_OTHER;
      pc_i           = '0;
      spr_addr_i     = '0;
      spr_wdat_i     = '0;
      eaddr_i        = '0;
      except_i       = '0;
      irq_i          = '0;
      branch_taken_i = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset values
      check_bit("branch_o", branch_o, 1'b0);
      check_bit("flush_o", flush_o, 1'b0);
      check_bit("stall_o", stall_o, 1'b0);
      check_bit("mfspr_we_o", mfspr_we_o, 1'b0);
      check_sr("sr_o", sr_o, 16'h8001);
      expect_spr("SR", SPR_SR_ADDR, 32'h0000_8001);
      expect_spr("EVBA", SPR_EVBA_ADDR, '0);
      expect_spr("EPCR", SPR_EPCR_ADDR, '0);

      // Write and read back
      v = rand_bits(32);
      write_spr(SPR_EPCR_ADDR, v);
      expect_spr("EPCR", SPR_EPCR_ADDR, v);
      v = rand_bits(32);
      write_spr(SPR_ESR_ADDR, v);
      expect_spr("ESR", SPR_ESR_ADDR, {16'd0, v[15:0]});
      v = rand_bits(32);
      write_spr(SPR_EVBA_ADDR, v);
      evba_exp = v & ~32'h0000_1FFF;
      expect_spr("EVBA", SPR_EVBA_ADDR, evba_exp);
      v = rand_bits(32);
      write_spr(SPR_PICMR_ADDR, v);
      expect_spr("PICMR", SPR_PICMR_ADDR, v);
      write_spr(16'h2804, rand_bits(32));
      expect_spr("group 5 SPR", 16'h2804, '0);

      // Synchronous exceptions, cancelled EVBA write included
      for (int i = 0; i < 8; i++) begin
         sr_val = sr_t'(rand_bits(16)) | 16'h0001;
         write_spr(SPR_SR_ADDR, {16'd0, sr_val});
         pc  = rand_bits(30) << 2;
         ea  = rand_bits(32);
         exc = exc_req_t'(rand_bits(5));
         while (exc == '0)
            exc = exc_req_t'(rand_bits(5));
         eaddr_i = ea;
         issue(OP_MTSPR, pc, SPR_EVBA_ADDR, rand_bits(32), exc);
         exp_entry(exc, 1'b0, pc, ea, evba_exp, redir, epcr, eear);
         take_redirect(redir);
         sr_exp         = sr_val;
         sr_exp[SR_SM]  = 1'b1;
         sr_exp[SR_TEE] = 1'b0;
         sr_exp[SR_IEE] = 1'b0;
         check_sr("sr_o", sr_o, sr_exp);
         expect_spr("EPCR", SPR_EPCR_ADDR, epcr);
         expect_spr("EEAR", SPR_EEAR_ADDR, eear);
         expect_spr("ESR", SPR_ESR_ADDR, {16'd0, sr_val});
         expect_spr("EVBA", SPR_EVBA_ADDR, evba_exp);
      end

      // Return from exception
      v      = rand_bits(32);
      sr_val = (sr_t'(rand_bits(16)) | 16'h0001) & ~16'h0006;
      write_spr(SPR_EPCR_ADDR, v);
      write_spr(SPR_ESR_ADDR, {16'd0, sr_val});
      pc_cnt = pc_cnt + 32'd4;
      issue(OP_RFE, pc_cnt, '0, '0, '0);
      take_redirect(v);
      check_sr("sr_o", sr_o, sr_val);

      // Tick timer, period 20 in restart mode
      write_spr(SPR_TTMR_ADDR, (32'd1 << TTMR_MODE_LO) | (32'd1 << TTMR_IE) | 32'd20);
      write_spr(SPR_SR_ADDR, 32'h0000_8003);
      commit_until_branch(pc);
      exp_entry('0, 1'b0, pc, '0, evba_exp, redir, epcr, eear);
      take_redirect(redir);
      check_word("branch_pc_o", branch_pc_o, evba_exp | 32'h500);
      check_sr("sr_o", sr_o, 16'h8001);
      expect_spr("EPCR", SPR_EPCR_ADDR, epcr);
      expect_spr("ESR", SPR_ESR_ADDR, 32'h0000_8003);
      write_spr(SPR_TTMR_ADDR, '0);

      // Interrupt controller
      k = int'(rand_bits(5));
      write_spr(SPR_PICMR_ADDR, 32'd1 << k);
      irq_i = rand_bits(32) | (32'd1 << k);
      expect_spr("PICSR", SPR_PICSR_ADDR, irq_i & (32'd1 << k));
      write_spr(SPR_SR_ADDR, 32'h0000_8005);
      commit_until_branch(pc);
      exp_entry('0, 1'b1, pc, '0, evba_exp, redir, epcr, eear);
      take_redirect(redir);
      check_word("branch_pc_o", branch_pc_o, evba_exp | 32'h800);
      expect_spr("EPCR", SPR_EPCR_ADDR, epcr);
      irq_i = '0;

      $display("Everything OK");
      $finish;
   end

endmodule

// File: list.f
logic/or1k_spr_pkg.sv
logic/or1k_exc_pkg.sv
logic/spr_if.sv
logic/exc_if.sv
logic/exc_fsm.sv
logic/tick_timer.sv
logic/pic.sv
logic/sys_spr_file.sv
logic/ctrl_top.sv
bench/tb_ctrl_top.sv

// File: logic/ctrl_top.sv
// Control unit top level
`timescale 1ns/1ps

module ctrl_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    insn_valid_i,
   input  or1k_exc_pkg::insn_op_t  insn_op_i,
   input  or1k_spr_pkg::word_t     pc_i,
   input  or1k_spr_pkg::spr_addr_t spr_addr_i,
   input  or1k_spr_pkg::word_t     spr_wdat_i,
   input  or1k_spr_pkg::word_t     eaddr_i,
   input  or1k_exc_pkg::exc_req_t  except_i,
   input  logic [31:0]             irq_i,
   input  logic                    branch_taken_i,
   output or1k_spr_pkg::word_t     mfspr_dat_o,
   output logic                    mfspr_we_o,
   output logic                    branch_o,
   output or1k_spr_pkg::word_t     branch_pc_o,
   output logic                    flush_o,
   output logic                    stall_o,
   output or1k_spr_pkg::sr_t       sr_o
);

   logic pic_irq;
   logic tick_irq;

   exc_if exc_bus ();
   spr_if pic_bus ();
   spr_if tick_bus ();

   exc_fsm u_exc_fsm (
      .clk            (clk),
      .rst            (rst),
      .insn_valid_i   (insn_valid_i),
      .insn_op_i      (insn_op_i),
      .except_i       (except_i),
      .pic_irq_i      (pic_irq),
      .tick_irq_i     (tick_irq),
      .branch_taken_i (branch_taken_i),
      .exc            (exc_bus),
      .branch_o       (branch_o),
      .flush_o        (flush_o),
      .stall_o        (stall_o)
   );

   sys_spr_file u_sys_spr_file (
      .clk          (clk),
      .rst          (rst),
      .insn_valid_i (insn_valid_i),
      .insn_op_i    (insn_op_i),
      .pc_i         (pc_i),
      .spr_addr_i   (spr_addr_i),
      .spr_wdat_i   (spr_wdat_i),
      .eaddr_i      (eaddr_i),
      .stall_i      (stall_o),
      .exc          (exc_bus),
      .pic_spr      (pic_bus),
      .tick_spr     (tick_bus),
      .mfspr_dat_o  (mfspr_dat_o),
      .mfspr_we_o   (mfspr_we_o),
      .branch_pc_o  (branch_pc_o),
      .sr_o         (sr_o)
   );

   pic u_pic (
      .clk       (clk),
      .rst       (rst),
      .irq_i     (irq_i),
      .spr       (pic_bus),
      .pic_irq_o (pic_irq)
   );

   tick_timer u_tick_timer (
      .clk        (clk),
      .rst        (rst),
      .spr        (tick_bus),
      .tick_irq_o (tick_irq)
   );

endmodule

// File: logic/exc_fsm.sv
// Exception and rfe control
`timescale 1ns/1ps

module exc_fsm (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   insn_valid_i,
   input  or1k_exc_pkg::insn_op_t insn_op_i,
   input  or1k_exc_pkg::exc_req_t except_i,
   input  logic                   pic_irq_i,
   input  logic                   tick_irq_i,
   input  logic                   branch_taken_i,
   exc_if.fsm                     exc,
   output logic                   branch_o,
   output logic                   flush_o,
   output logic                   stall_o
);
   import or1k_exc_pkg::*;

   exc_state_t state;
   logic       commit;
   logic       pic_take;
   logic       tick_take;

   assign commit = insn_valid_i && !stall_o;

   // Interrupts wait while an rfe commits so the return is not lost
   assign pic_take = commit && !(|except_i) && insn_op_i != OP_RFE &&
                     pic_irq_i && exc.sr_iee;
   assign tick_take = commit && !(|except_i) && insn_op_i != OP_RFE &&
                      tick_irq_i && exc.sr_tee;

   assign exc.entry = (commit && (|except_i)) || pic_take || tick_take;
   assign exc.rfe   = commit && !(|except_i) && insn_op_i == OP_RFE;

   // Fixed priority, synchronous causes first
   always_comb begin
      if (except_i[EXC_BUS])
         exc.cause = CAUSE_BUS;
      else if (except_i[EXC_ILLEGAL])
         exc.cause = CAUSE_ILLEGAL;
      else if (except_i[EXC_ALIGN])
         exc.cause = CAUSE_ALIGN;
      else if (except_i[EXC_SYSCALL])
         exc.cause = CAUSE_SYSCALL;
      else if (except_i[EXC_TRAP])
         exc.cause = CAUSE_TRAP;
      else if (pic_irq_i && exc.sr_iee)
         exc.cause = CAUSE_INT;
      else
         exc.cause = CAUSE_TICK;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         flush_o <= 1'b0;
      end else begin
         flush_o <= exc.entry || exc.rfe;
         case (state)
            ST_IDLE: begin
               if (exc.entry || exc.rfe)
                  state <= ST_REDIRECT;
            end
            // Hold the redirect until fetch takes it
            ST_REDIRECT: begin
               if (branch_taken_i)
                  state <= ST_TAKEN;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign branch_o = state == ST_REDIRECT;
   assign stall_o  = state != ST_IDLE;

   a_entry_rfe_excl: assert property (@(posedge clk) disable iff (rst)
      !(exc.entry && exc.rfe));

   // Flush only with a fresh redirect
   a_flush_with_branch: assert property (@(posedge clk) disable iff (rst)
      flush_o |-> branch_o);

endmodule

// File: logic/exc_if.sv
// Exception FSM to SPR file link
`timescale 1ns/1ps

interface exc_if;
   import or1k_exc_pkg::*;

   // Single-cycle pulses at the commit
   logic       entry;
   logic       rfe;
   exc_cause_t cause;
   // Live interrupt enables from SR
   logic       sr_iee;
   logic       sr_tee;

   modport fsm (output entry, output rfe, output cause, input sr_iee, input sr_tee);

   modport spr (input entry, input rfe, input cause, output sr_iee, output sr_tee);

endinterface

// File: logic/or1k_exc_pkg.sv
// OR1K exception causes and vectors

package or1k_exc_pkg;

   typedef enum logic [1:0] {
      OP_OTHER,
      OP_MTSPR,
      OP_MFSPR,
      OP_RFE
   } insn_op_t;

   // Synchronous causes, one bit each
   typedef logic [4:0] exc_req_t;

   localparam int EXC_BUS     = 0;
   localparam int EXC_ILLEGAL = 1;
   localparam int EXC_ALIGN   = 2;
   localparam int EXC_SYSCALL = 3;
   localparam int EXC_TRAP    = 4;

   typedef enum logic [2:0] {
      CAUSE_BUS,
      CAUSE_ILLEGAL,
      CAUSE_ALIGN,
      CAUSE_SYSCALL,
      CAUSE_TRAP,
      CAUSE_INT,
      CAUSE_TICK
   } exc_cause_t;

   // Vector numbers, placed at bit 8 of the handler address
   localparam logic [4:0] VEC_BUS     = 5'd2;
   localparam logic [4:0] VEC_TICK    = 5'd5;
   localparam logic [4:0] VEC_ALIGN   = 5'd6;
   localparam logic [4:0] VEC_ILLEGAL = 5'd7;
   localparam logic [4:0] VEC_INT     = 5'd8;
   localparam logic [4:0] VEC_SYSCALL = 5'd12;
   localparam logic [4:0] VEC_TRAP    = 5'd14;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REDIRECT,
      ST_TAKEN
   } exc_state_t;

endpackage

// File: logic/or1k_spr_pkg.sv
// OR1K SPR map and register types

package or1k_spr_pkg;

   typedef logic [31:0] word_t;
   typedef logic [15:0] spr_addr_t;
   typedef logic [4:0]  spr_group_t;
   typedef logic [15:0] sr_t;

   localparam sr_t SR_RESET = 16'h8001;

   // System group addresses
   localparam spr_addr_t SPR_SR_ADDR    = 16'h0011;
   localparam spr_addr_t SPR_PPC_ADDR   = 16'h0012;
   localparam spr_addr_t SPR_EVBA_ADDR  = 16'h000B;
   localparam spr_addr_t SPR_EPCR_ADDR  = 16'h0020;
   localparam spr_addr_t SPR_EEAR_ADDR  = 16'h0030;
   localparam spr_addr_t SPR_ESR_ADDR   = 16'h0040;
   localparam spr_addr_t SPR_PICMR_ADDR = 16'h4800;
   localparam spr_addr_t SPR_PICSR_ADDR = 16'h4802;
   localparam spr_addr_t SPR_TTMR_ADDR  = 16'h5000;
   localparam spr_addr_t SPR_TTCR_ADDR  = 16'h5001;

   localparam spr_group_t GRP_SYS  = 5'd0;
   localparam spr_group_t GRP_PIC  = 5'd9;
   localparam spr_group_t GRP_TICK = 5'd10;

   localparam int SR_SM  = 0;
   localparam int SR_TEE = 1;
   localparam int SR_IEE = 2;

   // Period sits below the IP bit
   localparam int TTMR_IP      = 28;
   localparam int TTMR_IE      = 29;
   localparam int TTMR_MODE_LO = 30;

   localparam int EVBA_LOW_BITS = 13;

endpackage

// File: logic/pic.sv
// Interrupt controller, level sensitive
`timescale 1ns/1ps

module pic (
   input  logic                clk,
   input  logic                rst,
   input  or1k_spr_pkg::word_t irq_i,
   spr_if.unit                 spr,
   output logic                pic_irq_o
);
   import or1k_spr_pkg::*;

   word_t picmr;
   word_t picsr;

   assign picsr = irq_i & picmr;

   always_ff @(posedge clk) begin
      if (rst) begin
         picmr <= '0;
      end else if (spr.sel && spr.we && spr.addr == SPR_PICMR_ADDR) begin
         picmr <= spr.wdat;
      end
   end

   // PICSR follows the lines, so writes to it have no effect
   always_comb begin
      case (spr.addr)
         SPR_PICMR_ADDR: spr.rdat = picmr;
         SPR_PICSR_ADDR: spr.rdat = picsr;
         default:        spr.rdat = '0;
      endcase
   end

   assign pic_irq_o = |picsr;

endmodule

// File: logic/spr_if.sv
// SPR group access bus
`timescale 1ns/1ps

interface spr_if;
   import or1k_spr_pkg::*;

   logic      sel;
   logic      we;
   spr_addr_t addr;
   word_t     wdat;
   // Read data, decoded from addr
   word_t     rdat;

   modport master (output sel, output we, output addr, output wdat, input rdat);

   modport unit (input sel, input we, input addr, input wdat, output rdat);

endinterface

// File: logic/sys_spr_file.sv
// System SPRs and SPR access decode
`timescale 1ns/1ps

module sys_spr_file (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    insn_valid_i,
   input  or1k_exc_pkg::insn_op_t  insn_op_i,
   input  or1k_spr_pkg::word_t     pc_i,
   input  or1k_spr_pkg::spr_addr_t spr_addr_i,
   input  or1k_spr_pkg::word_t     spr_wdat_i,
   input  or1k_spr_pkg::word_t     eaddr_i,
   input  logic                    stall_i,
   exc_if.spr                      exc,
   spr_if.master                   pic_spr,
   spr_if.master                   tick_spr,
   output or1k_spr_pkg::word_t     mfspr_dat_o,
   output logic                    mfspr_we_o,
   output or1k_spr_pkg::word_t     branch_pc_o,
   output or1k_spr_pkg::sr_t       sr_o
);
   import or1k_spr_pkg::*;
   import or1k_exc_pkg::*;

   sr_t        sr;
   sr_t        esr;
   word_t      epcr;
   word_t      eear;
   word_t      evba;
   word_t      ppc;
   spr_group_t group;
   logic       sync_exc;
   logic       performed;
   logic       spr_access;
   logic       sys_we;
   word_t      sys_rdat;
   word_t      rdat;
   logic [4:0] vec;

   assign group = spr_addr_i[15:11];

   // A synchronous exception cancels the instruction
   assign sync_exc   = exc.entry && exc.cause != CAUSE_INT && exc.cause != CAUSE_TICK;
   assign performed  = insn_valid_i && !stall_i && !sync_exc;
   assign spr_access = insn_valid_i && !stall_i &&
                       (insn_op_i == OP_MTSPR || insn_op_i == OP_MFSPR);
   assign sys_we     = performed && insn_op_i == OP_MTSPR && group == GRP_SYS;

   assign pic_spr.sel   = spr_access && group == GRP_PIC;
   assign pic_spr.we    = !sync_exc && insn_op_i == OP_MTSPR;
   assign pic_spr.addr  = spr_addr_i;
   assign pic_spr.wdat  = spr_wdat_i;
   assign tick_spr.sel  = spr_access && group == GRP_TICK;
   assign tick_spr.we   = !sync_exc && insn_op_i == OP_MTSPR;
   assign tick_spr.addr = spr_addr_i;
   assign tick_spr.wdat = spr_wdat_i;

   always_comb begin
      case (spr_addr_i)
         SPR_SR_ADDR:   sys_rdat = {16'd0, sr};
         SPR_PPC_ADDR:  sys_rdat = ppc;
         SPR_EVBA_ADDR: sys_rdat = evba;
         SPR_EPCR_ADDR: sys_rdat = epcr;
         SPR_EEAR_ADDR: sys_rdat = eear;
         SPR_ESR_ADDR:  sys_rdat = {16'd0, esr};
         default:       sys_rdat = '0;
      endcase
   end

   // Groups without a unit read as zero
   always_comb begin
      case (group)
         GRP_SYS:  rdat = sys_rdat;
         GRP_PIC:  rdat = pic_spr.rdat;
         GRP_TICK: rdat = tick_spr.rdat;
         default:  rdat = '0;
      endcase
   end

   always_comb begin
      case (exc.cause)
         CAUSE_BUS:     vec = VEC_BUS;
         CAUSE_ILLEGAL: vec = VEC_ILLEGAL;
         CAUSE_ALIGN:   vec = VEC_ALIGN;
         CAUSE_SYSCALL: vec = VEC_SYSCALL;
         CAUSE_TRAP:    vec = VEC_TRAP;
         CAUSE_INT:     vec = VEC_INT;
         default:       vec = VEC_TICK;
      endcase
   end

   // Entry to supervisor mode with interrupts masked
   always_ff @(posedge clk) begin
      if (rst) begin
         sr <= SR_RESET;
      end else if (exc.entry) begin
         sr[SR_SM]  <= 1'b1;
         sr[SR_TEE] <= 1'b0;
         sr[SR_IEE] <= 1'b0;
      end else if (exc.rfe) begin
         sr <= esr;
      end else if (sys_we && spr_addr_i == SPR_SR_ADDR && sr[SR_SM]) begin
         sr <= spr_wdat_i[15:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         esr  <= '0;
         epcr <= '0;
         eear <= '0;
      end else if (exc.entry) begin
         esr <= sr;
         // Resume after the instruction for syscall and interrupts
         if (exc.cause == CAUSE_SYSCALL || exc.cause == CAUSE_INT ||
             exc.cause == CAUSE_TICK) begin
            epcr <= pc_i + 32'd4;
         end else begin
            epcr <= pc_i;
         end
         eear <= (exc.cause == CAUSE_BUS || exc.cause == CAUSE_ALIGN) ? eaddr_i : pc_i;
      end else if (sys_we) begin
         if (spr_addr_i == SPR_ESR_ADDR)
            esr <= spr_wdat_i[15:0];
         if (spr_addr_i == SPR_EPCR_ADDR)
            epcr <= spr_wdat_i;
         if (spr_addr_i == SPR_EEAR_ADDR)
            eear <= spr_wdat_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         evba <= '0;
         ppc  <= '0;
      end else begin
         if (sys_we && spr_addr_i == SPR_EVBA_ADDR)
            evba <= {spr_wdat_i[31:EVBA_LOW_BITS], EVBA_LOW_BITS'(0)};
         if (performed)
            ppc <= pc_i;
      end
   end

   // Read data and redirect target, valid the cycle after the commit
   always_ff @(posedge clk) begin
      if (rst) begin
         mfspr_dat_o <= '0;
         mfspr_we_o  <= 1'b0;
         branch_pc_o <= '0;
      end else begin
         mfspr_we_o <= performed && insn_op_i == OP_MFSPR;
         if (performed && insn_op_i == OP_MFSPR)
            mfspr_dat_o <= rdat;
         if (exc.entry)
            branch_pc_o <= evba | {19'd0, vec, 8'd0};
         else if (exc.rfe)
            branch_pc_o <= epcr;
      end
   end

   assign exc.sr_iee = sr[SR_IEE];
   assign exc.sr_tee = sr[SR_TEE];
   assign sr_o       = sr;

   a_no_write_in_stall: assert property (@(posedge clk) disable iff (rst)
      stall_i |-> !(exc.entry || exc.rfe));

endmodule

// File: logic/tick_timer.sv
// Tick timer
`timescale 1ns/1ps

module tick_timer (
   input  logic clk,
   input  logic rst,
   spr_if.unit  spr,
   output logic tick_irq_o
);
   import or1k_spr_pkg::*;

   word_t      ttmr;
   word_t      ttcr;
   logic [1:0] mode;
   logic       match;
   logic       ttmr_we;
   logic       ttcr_we;

   assign mode    = ttmr[TTMR_MODE_LO +: 2];
   assign match   = ttcr[TTMR_IP-1:0] == ttmr[TTMR_IP-1:0];
   assign ttmr_we = spr.sel && spr.we && spr.addr == SPR_TTMR_ADDR;
   assign ttcr_we = spr.sel && spr.we && spr.addr == SPR_TTCR_ADDR;

   // Software clears IP by writing it low
   always_ff @(posedge clk) begin
      if (rst) begin
         ttmr <= '0;
      end else if (ttmr_we) begin
         ttmr <= spr.wdat;
      end else if (mode != 2'd0 && match) begin
         ttmr[TTMR_IP] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ttcr <= '0;
      end else if (ttcr_we) begin
         ttcr <= spr.wdat;
      end else begin
         case (mode)
            2'd1: ttcr <= match ? '0 : ttcr + 1'b1;
            2'd2: ttcr <= match ? ttcr : ttcr + 1'b1;
            2'd3: ttcr <= ttcr + 1'b1;
            default: ttcr <= ttcr;
         endcase
      end
   end

   always_comb begin
      case (spr.addr)
         SPR_TTMR_ADDR: spr.rdat = ttmr;
         SPR_TTCR_ADDR: spr.rdat = ttcr;
         default:       spr.rdat = '0;
      endcase
   end

   assign tick_irq_o = ttmr[TTMR_IP] && ttmr[TTMR_IE];

endmodule
